/* wb_defs.svh */
`ifndef WB_DEFS_SVH
`define WB_DEFS_SVH

// ******************************
// frame geometry
// ******************************
`define WB_H_ACT      16          // active pixels per line.
`define WB_V_ACT      8           // active lines per frame.
`define WB_X_W        4           // x coordinate width.
`define WB_Y_W        3           // y coordinate width.

// ******************************
// datapath widths
// ******************************
`define WB_SUM_W      16          // holds h_act * v_act * 255 without wrapping.
`define WB_GAIN_FRAC  12          // fraction bits of a gain.
`define WB_GAIN_W     16          // 4.12 unsigned gain.

// cycles from an input pixel to the matching output pixel.
`define WB_APPLY_LAT  3

`endif

/* wb_pkg.sv */
`include "wb_defs.svh"

package wb_pkg;

    // ******************************
    // stream fields
    // ******************************
    typedef logic [7:0]              pixel_t;    // one colour sample.
    typedef logic [`WB_X_W-1:0]      coord_x_t;
    typedef logic [`WB_Y_W-1:0]      coord_y_t;

    // ******************************
    // statistics and gains
    // ******************************
    typedef logic [`WB_SUM_W-1:0]    sum_t;      // one channel total over a frame.
    typedef logic [`WB_GAIN_W-1:0]   gain_t;     // 1 << WB_GAIN_FRAC is unity.

    // gain calculation sequence.
    typedef enum logic [1:0] {
        IDLE,
        MEAN,
        DIVIDE,
        DONE
    } div_state_t;

endpackage : wb_pkg

/* wb_frame_stats.sv */
`include "wb_defs.svh"

module wb_frame_stats (
    input  logic           clk,
    input  logic           i_rst_n,
    input  logic           i_vsync,
    input  logic           i_de,
    input  wb_pkg::pixel_t i_r,
    input  wb_pkg::pixel_t i_g,
    input  wb_pkg::pixel_t i_b,
    input  logic           i_update,
    output wb_pkg::sum_t   o_sum_r,
    output wb_pkg::sum_t   o_sum_g,
    output wb_pkg::sum_t   o_sum_b,
    output logic           o_sums_valid
);

    logic           vsync_d;
    logic           vs_rise;
    wb_pkg::pixel_t pix [3];
    wb_pkg::sum_t   acc [3];
    wb_pkg::sum_t   tot [3];

    assign vs_rise = i_vsync & ~vsync_d;
    assign pix[0]  = i_r;
    assign pix[1]  = i_g;
    assign pix[2]  = i_b;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            vsync_d      <= 1'b0;
            o_sums_valid <= 1'b0;
        end else begin
            vsync_d      <= i_vsync;
            o_sums_valid <= vs_rise & i_update;   // totals are stable from here on.
        end
    end

    // ******************************
    // running sums, one per channel
    // ******************************
    always_ff @(posedge clk) begin
        for (int c = 0; c < 3; c++) begin
            if (!i_rst_n) begin
                acc[c] <= '0;
            end else if (vs_rise) begin
                acc[c] <= '0;                     // a new frame starts.
            end else if (i_de) begin
                acc[c] <= acc[c] + wb_pkg::sum_t'(pix[c]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (vs_rise && i_update) begin
            tot <= acc;                           // the frame just finished.
        end
    end

    assign o_sum_r = tot[0];
    assign o_sum_g = tot[1];
    assign o_sum_b = tot[2];

    // a frame larger than the configured geometry would wrap the sums.
    for (genvar c = 0; c < 3; c++) begin : g_wrap
        a_no_wrap: assert property (@(posedge clk) disable iff (!i_rst_n)
            i_de && !vs_rise |=> acc[c] >= $past(acc[c]));
    end

endmodule : wb_frame_stats

/* wb_gain_calc.sv */
`include "wb_defs.svh"

module wb_gain_calc (
    input  logic          clk,
    input  logic          i_rst_n,
    input  wb_pkg::sum_t  i_sum_r,
    input  wb_pkg::sum_t  i_sum_g,
    input  wb_pkg::sum_t  i_sum_b,
    input  logic          i_sums_valid,
    output wb_pkg::gain_t o_gain_r,
    output wb_pkg::gain_t o_gain_g,
    output wb_pkg::gain_t o_gain_b
);

    localparam int DIV_W = `WB_SUM_W + `WB_GAIN_FRAC;   // quotient bits per channel.
    localparam int CNT_W = $clog2(DIV_W);
    localparam wb_pkg::gain_t UNITY = wb_pkg::gain_t'(1 << `WB_GAIN_FRAC);

    wb_pkg::div_state_t   state_r;
    logic [1:0]           ch_r;
    logic [CNT_W-1:0]     bit_r;
    wb_pkg::sum_t         sum_q [3];
    wb_pkg::sum_t         mean_r;
    wb_pkg::sum_t         rem_r;
    logic [DIV_W-1:0]     quo_r;
    wb_pkg::gain_t        gain_n [3];

    logic [`WB_SUM_W+1:0] total;
    wb_pkg::sum_t         mean_w;
    wb_pkg::sum_t         divisor;
    logic [`WB_SUM_W:0]   rem_sh;
    logic                 q_bit;
    wb_pkg::sum_t         rem_nxt;
    logic [DIV_W-1:0]     quo_nxt;
    logic                 last_bit;
    wb_pkg::gain_t        gain_w;

    // ******************************
    // one restoring divide step
    // ******************************
    always_comb begin
        total    = {2'b00, sum_q[0]} + {2'b00, sum_q[1]} + {2'b00, sum_q[2]};
        mean_w   = wb_pkg::sum_t'(total / 3);
        divisor  = sum_q[ch_r];
        rem_sh   = {rem_r, quo_r[DIV_W-1]};     // bring down the next dividend bit.
        q_bit    = (rem_sh >= {1'b0, divisor});
        rem_nxt  = q_bit ? wb_pkg::sum_t'(rem_sh - {1'b0, divisor}) : rem_sh[`WB_SUM_W-1:0];
        quo_nxt  = {quo_r[DIV_W-2:0], q_bit};
        last_bit = (bit_r == CNT_W'(DIV_W - 1));
        if (divisor == '0) begin
            gain_w = UNITY;                       // an empty channel is left alone.
        end else if (|quo_nxt[DIV_W-1:`WB_GAIN_W]) begin
            gain_w = '1;
        end else begin
            gain_w = quo_nxt[`WB_GAIN_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_r  <= wb_pkg::IDLE;
            ch_r     <= '0;
            bit_r    <= '0;
            o_gain_r <= UNITY;
            o_gain_g <= UNITY;
            o_gain_b <= UNITY;
        end else begin
            case (state_r)
                wb_pkg::IDLE: begin
                    if (i_sums_valid) begin
                        state_r <= wb_pkg::MEAN;
                    end
                end
                wb_pkg::MEAN: begin
                    state_r <= wb_pkg::DIVIDE;
                    ch_r    <= '0;
                    bit_r   <= '0;
                end
                wb_pkg::DIVIDE: begin
                    if (last_bit) begin
                        bit_r <= '0;
                        if (ch_r == 2'd2) begin
                            state_r <= wb_pkg::DONE;
                        end else begin
                            ch_r <= ch_r + 2'd1;
                        end
                    end else begin
                        bit_r <= bit_r + 1'b1;
                    end
                end
                wb_pkg::DONE: begin
                    o_gain_r <= gain_n[0];        // all three change together.
                    o_gain_g <= gain_n[1];
                    o_gain_b <= gain_n[2];
                    state_r  <= wb_pkg::IDLE;
                end
                default: state_r <= wb_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state_r)
            wb_pkg::IDLE: begin
                if (i_sums_valid) begin
                    sum_q <= '{i_sum_r, i_sum_g, i_sum_b};
                end
            end
            wb_pkg::MEAN: begin
                mean_r <= mean_w;
                rem_r  <= '0;
                quo_r  <= {mean_w, {`WB_GAIN_FRAC{1'b0}}};
            end
            wb_pkg::DIVIDE: begin
                if (last_bit) begin
                    gain_n[ch_r] <= gain_w;
                    rem_r        <= '0;       // restart on the next channel.
                    quo_r        <= {mean_r, {`WB_GAIN_FRAC{1'b0}}};
                end else begin
                    rem_r <= rem_nxt;
                    quo_r <= quo_nxt;
                end
            end
            default: ;
        endcase
    end

    // the statistics stage must not deliver a new frame mid-calculation.
    a_no_busy_strobe: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_sums_valid |-> state_r == wb_pkg::IDLE);

    // gains move only on DONE, so they hold unity until the first one.
    a_gain_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        $changed({o_gain_r, o_gain_g, o_gain_b}) |-> $past(state_r) == wb_pkg::DONE);

endmodule : wb_gain_calc

/* wb_gain_apply.sv */
`include "wb_defs.svh"

module wb_gain_apply (
    input  logic             clk,
    input  logic             i_rst_n,
    input  logic             i_en,
    input  logic             i_vsync,
    input  logic             i_hsync,
    input  logic             i_de,
    input  wb_pkg::pixel_t   i_r,
    input  wb_pkg::pixel_t   i_g,
    input  wb_pkg::pixel_t   i_b,
    input  wb_pkg::coord_x_t i_x,
    input  wb_pkg::coord_y_t i_y,
    input  wb_pkg::gain_t    i_gain_r,
    input  wb_pkg::gain_t    i_gain_g,
    input  wb_pkg::gain_t    i_gain_b,
    output logic             o_vsync,
    output logic             o_hsync,
    output logic             o_de,
    output wb_pkg::pixel_t   o_r,
    output wb_pkg::pixel_t   o_g,
    output wb_pkg::pixel_t   o_b,
    output wb_pkg::coord_x_t o_x,
    output wb_pkg::coord_y_t o_y
);

    localparam int LAT    = `WB_APPLY_LAT;
    localparam int TW     = 3 + `WB_X_W + `WB_Y_W;
    localparam int PROD_W = 8 + `WB_GAIN_W;

    wb_pkg::pixel_t                  pix_in  [3];
    wb_pkg::gain_t                   gain_in [3];
    wb_pkg::pixel_t                  pix_s1  [3];
    wb_pkg::gain_t                   gain_s1 [3];
    logic                            byp_s1;
    logic [PROD_W-1:0]               prod_s2 [3];
    wb_pkg::pixel_t                  pix_s2  [3];
    logic                            byp_s2;
    logic [PROD_W-`WB_GAIN_FRAC-1:0] scaled  [3];
    wb_pkg::pixel_t                  pix_s3  [3];
    logic [TW-1:0]                   tsr     [LAT];

    assign pix_in  = '{i_r, i_g, i_b};
    assign gain_in = '{i_gain_r, i_gain_g, i_gain_b};

    always_comb begin
        for (int c = 0; c < 3; c++) begin
            scaled[c] = prod_s2[c][PROD_W-1:`WB_GAIN_FRAC];  // drop the fraction.
        end
    end

    // ******************************
    // register, multiply, clamp
    // ******************************
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            byp_s1 <= 1'b0;
            byp_s2 <= 1'b0;
            for (int c = 0; c < 3; c++) begin
                pix_s1[c]  <= '0;
                gain_s1[c] <= '0;
                prod_s2[c] <= '0;
                pix_s2[c]  <= '0;
                pix_s3[c]  <= '0;
            end
        end else begin
            byp_s1 <= ~i_en;
            byp_s2 <= byp_s1;
            for (int c = 0; c < 3; c++) begin
                pix_s1[c]  <= pix_in[c];
                gain_s1[c] <= gain_in[c];
                prod_s2[c] <= pix_s1[c] * gain_s1[c];
                pix_s2[c]  <= pix_s1[c];
                if (byp_s2) begin
                    pix_s3[c] <= pix_s2[c];
                end else if (|scaled[c][PROD_W-`WB_GAIN_FRAC-1:8]) begin
                    pix_s3[c] <= 8'hFF;
                end else begin
                    pix_s3[c] <= scaled[c][7:0];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < LAT; i++) begin
                tsr[i] <= '0;
            end
        end else begin
            tsr[0] <= {i_vsync, i_hsync, i_de, i_x, i_y};
            for (int i = 1; i < LAT; i++) begin
                tsr[i] <= tsr[i-1];
            end
        end
    end

    assign {o_vsync, o_hsync, o_de, o_x, o_y} = tsr[LAT-1];
    assign o_r = pix_s3[0];
    assign o_g = pix_s3[1];
    assign o_b = pix_s3[2];

    a_de_outside_vsync: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_de |-> !o_vsync);

endmodule : wb_gain_apply

/* wb_top.sv */
module wb_top (
    input  logic             clk,
    input  logic             i_rst_n,
    input  logic             i_vsync,
    input  logic             i_hsync,
    input  logic             i_de,
    input  wb_pkg::pixel_t   i_r,
    input  wb_pkg::pixel_t   i_g,
    input  wb_pkg::pixel_t   i_b,
    input  wb_pkg::coord_x_t i_x,
    input  wb_pkg::coord_y_t i_y,
    input  logic             i_en,
    input  logic             i_update,
    output logic             o_vsync,
    output logic             o_hsync,
    output logic             o_de,
    output wb_pkg::pixel_t   o_r,
    output wb_pkg::pixel_t   o_g,
    output wb_pkg::pixel_t   o_b,
    output wb_pkg::coord_x_t o_x,
    output wb_pkg::coord_y_t o_y
);

    wb_pkg::sum_t  sum_r;
    wb_pkg::sum_t  sum_g;
    wb_pkg::sum_t  sum_b;
    logic          sums_valid;
    wb_pkg::gain_t gain_r;
    wb_pkg::gain_t gain_g;
    wb_pkg::gain_t gain_b;

    wb_frame_stats u_frame_stats (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_vsync     (i_vsync),
        .i_de        (i_de),
        .i_r         (i_r),
        .i_g         (i_g),
        .i_b         (i_b),
        .i_update    (i_update),
        .o_sum_r     (sum_r),
        .o_sum_g     (sum_g),
        .o_sum_b     (sum_b),
        .o_sums_valid(sums_valid)
    );

    wb_gain_calc u_gain_calc (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_sum_r     (sum_r),
        .i_sum_g     (sum_g),
        .i_sum_b     (sum_b),
        .i_sums_valid(sums_valid),
        .o_gain_r    (gain_r),
        .o_gain_g    (gain_g),
        .o_gain_b    (gain_b)
    );

    // the live stream is corrected with the gains of an earlier frame.
    wb_gain_apply u_gain_apply (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_en    (i_en),
        .i_vsync (i_vsync),
        .i_hsync (i_hsync),
        .i_de    (i_de),
        .i_r     (i_r),
        .i_g     (i_g),
        .i_b     (i_b),
        .i_x     (i_x),
        .i_y     (i_y),
        .i_gain_r(gain_r),
        .i_gain_g(gain_g),
        .i_gain_b(gain_b),
        .o_vsync (o_vsync),
        .o_hsync (o_hsync),
        .o_de    (o_de),
        .o_r     (o_r),
        .o_g     (o_g),
        .o_b     (o_b),
        .o_x     (o_x),
        .o_y     (o_y)
    );

endmodule : wb_top

/* tb_wb_top.sv */
`include "wb_defs.svh"

module tb_wb_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_CYC = 4 + 200 + `WB_V_ACT * (`WB_H_ACT + 4) + 4;
    localparam int TIMEOUT   = 6 * FRAME_CYC + 500;       // six frames in all.
    localparam int REC_W     = 3 + `WB_X_W + `WB_Y_W + 24;
    localparam wb_pkg::gain_t UNITY = wb_pkg::gain_t'(1 << `WB_GAIN_FRAC);

    logic             clk;
    logic             i_rst_n;
    logic             i_vsync;
    logic             i_hsync;
    logic             i_de;
    logic             i_en;
    logic             i_update;
    wb_pkg::pixel_t   i_r;
    wb_pkg::pixel_t   i_g;
    wb_pkg::pixel_t   i_b;
    wb_pkg::coord_x_t i_x;
    wb_pkg::coord_y_t i_y;
    logic             o_vsync;
    logic             o_hsync;
    logic             o_de;
    wb_pkg::pixel_t   o_r;
    wb_pkg::pixel_t   o_g;
    wb_pkg::pixel_t   o_b;
    wb_pkg::coord_x_t o_x;
    wb_pkg::coord_y_t o_y;

    logic [31:0]      lfsr_state = 32'h2075f999;
    int               ms_r;
    int               ms_g;
    int               ms_b;
    wb_pkg::gain_t    mg_r;
    wb_pkg::gain_t    mg_g;
    wb_pkg::gain_t    mg_b;
    logic             cur_en;
    logic             cur_upd;
    logic [REC_W-1:0] exp_q [$];                          // expected outputs, oldest first.
    int               n_checks = 0;
    int               n_errors = 0;
    int               n_clamped = 0;
    int               cycle_cnt = 0;
    string            test_name;
    int               chk0;
    int               err0;

    wb_top wb_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ******************************
    // random numbers and model
    // ******************************
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        int v;
        v = 0;
        for (int i = 0; i < 16; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return lo + v % (hi - lo + 1);
    endfunction

    // gain is mean / sum in 4.12, unity for an empty channel.
    function automatic wb_pkg::gain_t gain_of(input int mean, input int sum);
        longint q;
        if (sum == 0) begin
            return UNITY;
        end
        q = (longint'(mean) <<< `WB_GAIN_FRAC) / longint'(sum);
        if (q > longint'((1 << `WB_GAIN_W) - 1)) begin
            return '1;
        end
        return wb_pkg::gain_t'(q);
    endfunction

    function automatic wb_pkg::pixel_t corrected(input wb_pkg::pixel_t p,
                                                 input wb_pkg::gain_t g, input logic en);
        int scaled;
        scaled = (int'(p) * int'(g)) >>> `WB_GAIN_FRAC;
        if (!en) begin
            return p;
        end
        return (scaled > 255) ? 8'hFF : wb_pkg::pixel_t'(scaled);
    endfunction

    task automatic compare_field(input string name, input logic [15:0] exp,
                                 input logic [15:0] act);
        n_checks++;
        assert (act === exp) else begin
            $display("ERROR %0t ns %s expected %0h actual %0h", $time, name, exp, act);
            n_errors++;
        end
    endtask

    // ******************************
    // stimulus
    // ******************************
    task automatic drive_cycle(input logic vs, input logic hs, input logic de,
                               input wb_pkg::pixel_t pr, input wb_pkg::pixel_t pg,
                               input wb_pkg::pixel_t pb, input wb_pkg::coord_x_t px,
                               input wb_pkg::coord_y_t py);
        @(posedge clk);
        i_vsync  <= vs;
        i_hsync  <= hs;
        i_de     <= de;
        i_r      <= pr;
        i_g      <= pg;
        i_b      <= pb;
        i_x      <= px;
        i_y      <= py;
        i_en     <= cur_en;
        i_update <= cur_upd;
        exp_q.push_back({vs, hs, de, px, py, corrected(pr, mg_r, cur_en),
                         corrected(pg, mg_g, cur_en), corrected(pb, mg_b, cur_en)});
    endtask

    task automatic run_frame(input logic en, input logic upd, input int lo_r, input int hi_r,
                             input int lo_g, input int hi_g, input int lo_b, input int hi_b);
        wb_pkg::pixel_t pr;
        wb_pkg::pixel_t pg;
        wb_pkg::pixel_t pb;
        int             mean;
        cur_en  = en;
        cur_upd = upd;
        if (upd) begin                                    // the frame just ended sets the gains.
            mean = (ms_r + ms_g + ms_b) / 3;
            mg_r = gain_of(mean, ms_r);
            mg_g = gain_of(mean, ms_g);
            mg_b = gain_of(mean, ms_b);
        end
        ms_r = 0;
        ms_g = 0;
        ms_b = 0;
        repeat (4) drive_cycle(1'b1, 1'b0, 1'b0, '0, '0, '0, '0, '0);
        repeat (200) drive_cycle(1'b0, 1'b0, 1'b0, '0, '0, '0, '0, '0);
        for (int y = 0; y < `WB_V_ACT; y++) begin
            for (int x = 0; x < `WB_H_ACT; x++) begin
                pr = wb_pkg::pixel_t'(rand_range(lo_r, hi_r));
                pg = wb_pkg::pixel_t'(rand_range(lo_g, hi_g));
                pb = wb_pkg::pixel_t'(rand_range(lo_b, hi_b));
                ms_r += int'(pr);
                ms_g += int'(pg);
                ms_b += int'(pb);
                drive_cycle(1'b0, 1'b0, 1'b1, pr, pg, pb, wb_pkg::coord_x_t'(x),
                            wb_pkg::coord_y_t'(y));
            end
            for (int h = 0; h < 4; h++) begin
                drive_cycle(1'b0, h < 2, 1'b0, '0, '0, '0, '0, wb_pkg::coord_y_t'(y));
            end
        end
        repeat (4) drive_cycle(1'b0, 1'b0, 1'b0, '0, '0, '0, '0, '0);  // drain the pipeline.
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        chk0      = n_checks;
        err0      = n_errors;
    endtask

    task automatic end_test();
        compare_field("gain_r", mg_r, wb_top_i.gain_r);
        compare_field("gain_g", mg_g, wb_top_i.gain_g);
        compare_field("gain_b", mg_b, wb_top_i.gain_b);
        $display("%-12s %0d checks, %0d errors", test_name, n_checks - chk0, n_errors - err0);
    endtask

    // outputs are compared at the falling edge, three cycles after the drive.
    always @(negedge clk) begin : check_outputs
        logic             e_vs;
        logic             e_hs;
        logic             e_de;
        wb_pkg::coord_x_t e_x;
        wb_pkg::coord_y_t e_y;
        wb_pkg::pixel_t   e_r;
        wb_pkg::pixel_t   e_g;
        wb_pkg::pixel_t   e_b;
        if (exp_q.size() > `WB_APPLY_LAT) begin
            {e_vs, e_hs, e_de, e_x, e_y, e_r, e_g, e_b} = exp_q.pop_front();
            compare_field("o_vsync", e_vs, o_vsync);
            compare_field("o_hsync", e_hs, o_hsync);
            compare_field("o_de", e_de, o_de);
            compare_field("o_x", e_x, o_x);
            compare_field("o_y", e_y, o_y);
            compare_field("o_r", e_r, o_r);
            compare_field("o_g", e_g, o_g);
            compare_field("o_b", e_b, o_b);
            if (e_de && o_de && o_b == 8'hFF) begin
                n_clamped++;
            end
        end
    end

    initial begin
        while (cycle_cnt < TIMEOUT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
        $display("Test failures found");
        $finish;
    end

    // ******************************
    // test sequence
    // ******************************
    initial begin
        i_rst_n  = 1'b0;
        i_vsync  = 1'b0;
        i_hsync  = 1'b0;
        i_de     = 1'b0;
        i_en     = 1'b0;
        i_update = 1'b0;
        i_r      = '0;
        i_g      = '0;
        i_b      = '0;
        i_x      = '0;
        i_y      = '0;
        cur_en   = 1'b0;
        cur_upd  = 1'b0;
        mg_r     = UNITY;
        mg_g     = UNITY;
        mg_b     = UNITY;
        ms_r     = 0;
        ms_g     = 0;
        ms_b     = 0;
        repeat (3) @(posedge clk);
        i_rst_n <= 1'b1;

        begin_test("unity");
        run_frame(1'b1, 1'b0, 100, 200, 50, 150, 0, 100);
        end_test();
        begin_test("correction");
        run_frame(1'b1, 1'b1, 100, 200, 50, 150, 0, 100);
        end_test();
        begin_test("bypass");
        run_frame(1'b0, 1'b0, 0, 255, 0, 255, 0, 255);
        end_test();
        begin_test("hold");
        run_frame(1'b1, 1'b0, 0, 255, 0, 255, 0, 255);
        end_test();

        begin_test("saturation");
        run_frame(1'b1, 1'b1, 200, 255, 200, 255, 4, 12);  // very little blue.
        n_clamped = 0;
        run_frame(1'b1, 1'b1, 0, 255, 0, 255, 0, 255);
        assert (wb_top_i.gain_b > 4 * UNITY) else begin
            $display("the blue gain after a blue-poor frame is not large");
            n_errors++;
        end
        assert (n_clamped > 0) else begin
            $display("no blue output pixel was clamped at 255");
            n_errors++;
        end
        end_test();

        $display("5 tests, %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : tb_wb_top

/* list.f */
+incdir+.
wb_pkg.sv
wb_frame_stats.sv
wb_gain_calc.sv
wb_gain_apply.sv
wb_top.sv
tb_wb_top.sv

/* run.sh */
#!/bin/sh
# Build the white balance testbench with Verilator, run it, and judge the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module tb_wb_top -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    exit 1
fi
exit 0
